/* src/boardTestPkg.sv */
package boardTestPkg;

   ///////////////////////////////////////////////////////////////////////
   // Computer buses observed by the harness

   typedef struct packed
   {
      logic [31:0] portA;
      logic [31:0] portB;
      logic [31:0] portC;
      logic [31:0] portD;
      logic [31:0] tmr;
      logic [31:0] ctr;
      logic [31:0] tr;
      logic [31:0] treg;
      logic [31:0] mdi;
      logic [31:0] mdo;
      logic [31:0] addr;
   } compBus_t;

   // Sampled board buttons
   typedef struct packed
   {
      logic btnC;
      logic btnU;
      logic btnD;
      logic btnL;
      logic btnR;
   } buttons_t;

   // Display word, seen whole by the selector and per digit by the scanner
   typedef union packed
   {
      logic [31:0]     word;
      logic [7:0][3:0] nibble;
   } dispWord_u;

   ///////////////////////////////////////////////////////////////////////
   // Switch field codes

   // sw[15:12], codes 3 to F all count centre presses
   typedef enum logic [3:0]
   {
      clkSel1Hz   = 4'h0,
      clkSel10Hz  = 4'h1,
      clkSelFull  = 4'h2,
      clkSelPress = 4'h3
   } clkSel_e;

   // sw[7:4], same order as the old board harness
   typedef enum logic [3:0]
   {
      dispPortA = 4'h0,
      dispPortB = 4'h1,
      dispPortC = 4'h2,
      dispPortD = 4'h3,
      dispCount = 4'h4,
      dispZero5 = 4'h5,
      dispTmr   = 4'h6,
      dispCtr   = 4'h7,
      dispTr    = 4'h8,
      dispTreg  = 4'h9,
      dispPortI = 4'hA,
      dispPortJ = 4'hB,
      dispZeroC = 4'hC,
      dispMdi   = 4'hD,
      dispMdo   = 4'hE,
      dispAddr  = 4'hF
   } dispSel_e;

   // Active-low gfedcba patterns, index 0 is the leftmost entry
   localparam logic [0:15][6:0] segHex =
   {
      7'h40, 7'h79, 7'h24, 7'h30,
      7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03,
      7'h46, 7'h21, 7'h06, 7'h0E
   };

endpackage

/* src/tickGen.sv */
`timescale 1ns/1ps

module tickGen
#(
   parameter int TICK_DIV = 10
)
(
   input  logic f100Hz,
   input  logic res,
   output logic tick10,
   output logic tick1
);

   localparam int cntWidth = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
   localparam logic [cntWidth-1:0] lastCnt = cntWidth'(TICK_DIV - 1);

   logic [cntWidth-1:0] fastCnt;
   logic [cntWidth-1:0] slowCnt;
   logic                fastWrap;
   logic                slowWrap;

   assign fastWrap = (fastCnt == lastCnt);
   assign slowWrap = (slowCnt == lastCnt);

   // Slow counter only moves on the fast counter's wrap
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         fastCnt <= '0;
         slowCnt <= '0;
         tick10  <= 1'b0;
         tick1   <= 1'b0;
      end
      else
      begin
         fastCnt <= fastWrap ? '0 : fastCnt + 1'b1;
         if (fastWrap)
         begin
            slowCnt <= slowWrap ? '0 : slowCnt + 1'b1;
         end
         tick10 <= fastWrap;
         // Coincides with a tick10
         tick1  <= fastWrap & slowWrap;
      end
   end

endmodule

/* src/inputSampler.sv */
`timescale 1ns/1ps

module inputSampler
   import boardTestPkg::*;
(
   input  logic        f100Hz,
   input  logic        res,
   input  logic [15:0] sw,
   input  logic        btnC,
   input  logic        btnU,
   input  logic        btnD,
   input  logic        btnL,
   input  logic        btnR,
   output buttons_t    buttons,
   output logic [15:0] switches,
   output logic        pressC
);

   logic prevC;

   ///////////////////////////////////////////////////////////////////////
   // Board input registers

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         buttons  <= '0;
         switches <= '0;
      end
      else
      begin
         buttons.btnC <= btnC;
         buttons.btnU <= btnU;
         buttons.btnD <= btnD;
         buttons.btnL <= btnL;
         buttons.btnR <= btnR;
         switches     <= sw;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Centre button edge

   // One pulse per rising edge of the sampled button
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         prevC  <= 1'b0;
         pressC <= 1'b0;
      end
      else
      begin
         prevC  <= buttons.btnC;
         pressC <= buttons.btnC & ~prevC;
      end
   end

endmodule

/* src/eventCounter.sv */
`timescale 1ns/1ps

module eventCounter
   import boardTestPkg::*;
(
   input  logic        f100Hz,
   input  logic        res,
   input  clkSel_e     clkSel,
   input  logic        tick10,
   input  logic        tick1,
   input  logic        pressC,
   output logic [31:0] count
);

   logic countEn;

   // Strobe picked by the rate switches
   always_comb
   begin
      case (clkSel)
         clkSel1Hz:
         begin
            countEn = tick1;
         end
         clkSel10Hz:
         begin
            countEn = tick10;
         end
         clkSelFull:
         begin
            countEn = 1'b1;
         end
         default:
         begin
            // Every remaining code counts presses
            countEn = pressC;
         end
      endcase
   end

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         count <= '0;
      end
      else if (countEn)
      begin
         count <= count + 32'd1;
      end
   end

endmodule

/* src/displayMux.sv */
`timescale 1ns/1ps

module displayMux
   import boardTestPkg::*;
(
   input  dispSel_e    dispSel,
   input  compBus_t    comp,
   input  logic [31:0] count,
   input  buttons_t    buttons,
   input  logic [15:0] switches,
   output dispWord_u   word
);

   logic [31:0] portI;
   logic [31:0] portJ;

   // Button bit order L R U D C, as on the old harness
   assign portI = {27'd0, buttons.btnL, buttons.btnR, buttons.btnU,
                   buttons.btnD, buttons.btnC};
   assign portJ = {16'd0, switches};

   always_comb
   begin
      case (dispSel)
         dispPortA: word.word = comp.portA;
         dispPortB: word.word = comp.portB;
         dispPortC: word.word = comp.portC;
         dispPortD: word.word = comp.portD;
         dispCount: word.word = count;
         dispZero5: word.word = 32'd0;
         dispTmr:   word.word = comp.tmr;
         dispCtr:   word.word = comp.ctr;
         dispTr:    word.word = comp.tr;
         dispTreg:  word.word = comp.treg;
         dispPortI: word.word = portI;
         dispPortJ: word.word = portJ;
         dispZeroC: word.word = 32'd0;
         dispMdi:   word.word = comp.mdi;
         dispMdo:   word.word = comp.mdo;
         dispAddr:  word.word = comp.addr;
         default:   word.word = 32'd0;
      endcase
   end

endmodule

/* src/segScan.sv */
`timescale 1ns/1ps

module segScan
   import boardTestPkg::*;
#(
   parameter int DIGITS = 8
)
(
   input  logic              f100Hz,
   input  logic              res,
   input  dispWord_u         word,
   output logic [7:0]        seg,
   output logic [DIGITS-1:0] an
);

   localparam int idxWidth = (DIGITS > 1) ? $clog2(DIGITS) : 1;
   localparam logic [idxWidth-1:0] lastIdx = idxWidth'(DIGITS - 1);

   logic [idxWidth-1:0] digitIdx;
   logic [3:0]          curNibble;
   logic [6:0]          curPattern;
   logic [DIGITS-1:0]   curAnode;

   ///////////////////////////////////////////////////////////////////////
   // Digit rotation

   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         digitIdx <= '0;
      end
      else
      begin
         digitIdx <= (digitIdx == lastIdx) ? '0 : digitIdx + 1'b1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Segment encode

   // Nibble view of the display word
   assign curNibble  = word.nibble[digitIdx];
   assign curPattern = segHex[curNibble];
   // One anode low at the current position
   assign curAnode   = ~(DIGITS'(1) << digitIdx);

   // Pattern and anode leave together, one cycle behind the index
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         seg <= '1;
         an  <= '1;
      end
      else
      begin
         seg <= {1'b1, curPattern};
         an  <= curAnode;
      end
   end

endmodule

/* src/boardTest.sv */
`timescale 1ns/1ps

module boardTest
   import boardTestPkg::*;
#(
   parameter int TICK_DIV = 10,
   parameter int DIGITS   = 8
)
(
   input  logic        f100Hz,
   input  logic        res,
   input  logic [15:0] sw,
   input  logic        btnC,
   input  logic        btnU,
   input  logic        btnD,
   input  logic        btnL,
   input  logic        btnR,
   input  compBus_t    comp,
   output logic [15:0] leds,
   output logic [7:0]  seg,
   output logic [7:0]  an
);

   buttons_t    buttons;
   logic [15:0] switches;
   logic        pressC;
   logic        tick10;
   logic        tick1;
   logic [31:0] count;
   dispWord_u   dispWord;

   ///////////////////////////////////////////////////////////////////////
   // Inputs and event counting

   inputSampler inputSampler_i
   (
      .f100Hz   (f100Hz),
      .res      (res),
      .sw       (sw),
      .btnC     (btnC),
      .btnU     (btnU),
      .btnD     (btnD),
      .btnL     (btnL),
      .btnR     (btnR),
      .buttons  (buttons),
      .switches (switches),
      .pressC   (pressC)
   );

   tickGen #(.TICK_DIV(TICK_DIV)) tickGen_i
   (
      .f100Hz (f100Hz),
      .res    (res),
      .tick10 (tick10),
      .tick1  (tick1)
   );

   // Rate code sits on the top four switches
   eventCounter eventCounter_i
   (
      .f100Hz (f100Hz),
      .res    (res),
      .clkSel (clkSel_e'(switches[15:12])),
      .tick10 (tick10),
      .tick1  (tick1),
      .pressC (pressC),
      .count  (count)
   );

   ///////////////////////////////////////////////////////////////////////
   // Display path

   displayMux displayMux_i
   (
      .dispSel  (dispSel_e'(switches[7:4])),
      .comp     (comp),
      .count    (count),
      .buttons  (buttons),
      .switches (switches),
      .word     (dispWord)
   );

   segScan #(.DIGITS(DIGITS)) segScan_i
   (
      .f100Hz (f100Hz),
      .res    (res),
      .word   (dispWord),
      .seg    (seg),
      .an     (an)
   );

   assign leds = comp.portB[15:0];

endmodule

/* tests/boardTest_checker.sv */
`timescale 1ns/1ps

module segScanChecker
#(
   parameter int DIGITS = 8
)
(
   input logic                       f100Hz,
   input logic                       res,
   input logic [7:0]                 seg,
   input logic [DIGITS-1:0]          an,
   input logic [$clog2(DIGITS)-1:0]  digitIdx
);

   logic started;
   int   idleCycles [DIGITS];
   logic allVisited;

   // High from the second cycle after reset
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         started <= 1'b0;
      end
      else
      begin
         started <= 1'b1;
      end
   end

   // Cycles since each position was last scanned
   always_ff @(posedge f100Hz or posedge res)
   begin
      if (res)
      begin
         for (int p = 0; p < DIGITS; p++)
         begin
            idleCycles[p] <= 0;
         end
      end
      else
      begin
         for (int p = 0; p < DIGITS; p++)
         begin
            idleCycles[p] <= (int'(digitIdx) == p) ? 0 : idleCycles[p] + 1;
         end
      end
   end

   always_comb
   begin
      allVisited = 1'b1;
      for (int p = 0; p < DIGITS; p++)
      begin
         if (idleCycles[p] >= DIGITS)
         begin
            allVisited = 1'b0;
         end
      end
   end

   anodeOneLow: assert property (@(posedge f100Hz) disable iff (res)
      started |-> $onehot(~an))
      else $error("anode pattern %b does not light exactly one digit", an);

   pointOff: assert property (@(posedge f100Hz) seg[7])
      else $error("decimal point segment driven low");

   // Every position comes round within DIGITS cycles
   indexVisit: assert property (@(posedge f100Hz) disable iff (res)
      allVisited)
      else $error("a digit position went %0d cycles without a scan", DIGITS);

endmodule

bind segScan segScanChecker #(.DIGITS(DIGITS)) segScanChecker_i
(
   .f100Hz   (f100Hz),
   .res      (res),
   .seg      (seg),
   .an       (an),
   .digitIdx (digitIdx)
);

/* tests/boardTestTb.sv */
`timescale 1ns/1ps

module boardTestTb
   import boardTestPkg::*;
();

   logic        f100Hz;
   logic        res;
   logic [15:0] sw;
   // Buttons packed as L R U D C, the port I bit order
   logic [4:0]  btns;
   compBus_t    comp;
   logic [15:0] leds;
   logic [7:0]  seg;
   logic [7:0]  an;
   int          cycleCnt = 0;
   int          failCnt = 0;
   int          testCnt = 0;

   boardTest boardTest_i
   (
      .f100Hz (f100Hz),
      .res    (res),
      .sw     (sw),
      .btnC   (btns[0]),
      .btnU   (btns[2]),
      .btnD   (btns[1]),
      .btnL   (btns[4]),
      .btnR   (btns[3]),
      .comp   (comp),
      .leds   (leds),
      .seg    (seg),
      .an     (an)
   );

   initial
   begin
      f100Hz = 1'b0;
      forever #10 f100Hz = ~f100Hz;
   end

   always @(posedge f100Hz)
   begin
      cycleCnt <= cycleCnt + 1;
   end

   ///////////////////////////////////////////////////////////////////////
   // Helpers

   // Inputs change 1 ns after the rising edge
   task automatic stepCycles(input int n);
      repeat (n) @(posedge f100Hz);
      #1;
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
         failCnt++;
      end
   endtask

   task automatic checkRange(input string name, input int got, input int lo, input int hi);
      assert (got >= lo && got <= hi)
      else
      begin
         $display("mismatch at %0t: %s is %0d, expected %0d to %0d", $time, name, got, lo, hi);
         failCnt++;
      end
   endtask

   task automatic finishTest(input string name, input int failsBefore);
      testCnt++;
      if (failCnt == failsBefore)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         $display("test %s: %0d failed checks", name, failCnt - failsBefore);
      end
   endtask

   // Bit 4 set when the pattern is a known hex digit
   function automatic logic [4:0] segToNibble(input logic [7:0] s);
      logic [4:0] result;
      int         i;
      result = 5'd0;
      for (i = 0; i < 16; i++)
      begin
         if (s == {1'b1, segHex[i]})
         begin
            result = {1'b1, 4'(i)};
         end
      end
      return result;
   endfunction

   // Select table of the display
   function automatic logic [31:0] expectedWord(input logic [3:0] code,
      input logic [31:0] countExp, input logic [31:0] portI, input logic [31:0] portJ);
      case (code)
         4'h0: return comp.portA;
         4'h1: return comp.portB;
         4'h2: return comp.portC;
         4'h3: return comp.portD;
         4'h4: return countExp;
         4'h6: return comp.tmr;
         4'h7: return comp.ctr;
         4'h8: return comp.tr;
         4'h9: return comp.treg;
         4'hA: return portI;
         4'hB: return portJ;
         4'hD: return comp.mdi;
         4'hE: return comp.mdo;
         4'hF: return comp.addr;
         default: return 32'd0;
      endcase
   endfunction

   task automatic randomizeComp();
      comp = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom(), $urandom(),
              $urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
   endtask

   task automatic applyReset(input logic [15:0] swInit);
      res = 1'b1;
      stepCycles(4);
      res = 1'b0;
      sw = swInit;
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Display readback

   // One full scan from digit 0, ends just after a rising edge
   task automatic collectScan(output logic [31:0] word, output int scanCycle);
      int         waitCnt;
      int         k;
      logic [4:0] nib;
      logic [7:0] expAn;
      word = '0;
      waitCnt = 0;
      @(negedge f100Hz);
      while (an !== 8'hFE && waitCnt < 32)
      begin
         @(negedge f100Hz);
         waitCnt++;
      end
      scanCycle = cycleCnt;
      if (an !== 8'hFE)
      begin
         $display("timeout at %0t: the first digit never lit", $time);
         failCnt++;
      end
      else
      begin
         for (k = 0; k < 8; k++)
         begin
            if (k > 0)
            begin
               @(negedge f100Hz);
            end
            expAn = ~(8'h01 << k);
            checkValue("an", {24'd0, an}, {24'd0, expAn});
            nib = segToNibble(seg);
            assert (nib[4])
            else
            begin
               $display("undecodable segment pattern %h at %0t", seg, $time);
               failCnt++;
            end
            word[4*k +: 4] = nib[3:0];
         end
      end
      stepCycles(1);
   endtask

   // A low digit above 8 may carry into digits scanned later, so rescan
   task automatic readCount(output logic [31:0] value, output int scanCycle);
      int attempt;
      attempt = 0;
      collectScan(value, scanCycle);
      while (value[3:0] > 4'd8 && attempt < 3)
      begin
         collectScan(value, scanCycle);
         attempt++;
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Tests

   initial
   begin
      logic [31:0] got;
      logic [31:0] first;
      logic [31:0] swRand;
      int          t0;
      int          t1;
      int          fails;
      int          n;
      void'($urandom(32'h5b9));
      res = 1'b1;
      sw = '0;
      btns = '0;
      randomizeComp();

      fails = failCnt;
      applyReset(16'h0000);
      collectScan(got, t0);
      checkValue("display", got, comp.portA);
      checkValue("leds", {16'd0, leds}, {16'd0, comp.portB[15:0]});
      finishTest("reset view", fails);

      // Press mode with no presses keeps the count at 0
      fails = failCnt;
      randomizeComp();
      applyReset(16'h3000);
      btns = 5'($urandom()) & 5'b11110;
      swRand = $urandom();
      for (n = 0; n < 16; n++)
      begin
         sw = {4'h3, swRand[11:8], 4'(n), swRand[3:0]};
         stepCycles(3);
         collectScan(got, t0);
         checkValue($sformatf("display code %h", n), got,
                    expectedWord(4'(n), 32'd0, {27'd0, btns}, {16'd0, sw}));
      end
      finishTest("select codes", fails);

      fails = failCnt;
      btns = '0;
      sw = 16'hF040;
      stepCycles(3);
      readCount(first, t0);
      for (n = 1; n <= 3; n++)
      begin
         btns[0] = 1'b1;
         stepCycles(3);
         btns[0] = 1'b0;
         stepCycles(3);
         readCount(got, t1);
         checkValue("count after press", got, first + n);
      end
      // Long hold gives a single event
      btns[0] = 1'b1;
      stepCycles(20);
      readCount(got, t1);
      checkValue("count while held", got, first + 4);
      btns[0] = 1'b0;
      stepCycles(3);
      readCount(got, t1);
      checkValue("count after hold", got, first + 4);
      finishTest("centre presses", fails);

      fails = failCnt;
      sw = 16'h2040;
      stepCycles(3);
      readCount(first, t0);
      stepCycles(40);
      readCount(got, t1);
      checkRange("count growth every clock", got - first, t1 - t0 - 2, t1 - t0 + 2);
      finishTest("free run", fails);

      fails = failCnt;
      sw = 16'h1040;
      stepCycles(3);
      readCount(first, t0);
      stepCycles(300);
      readCount(got, t1);
      checkRange("count growth 10 Hz", got - first, (t1 - t0) / 10 - 1, (t1 - t0) / 10 + 1);
      sw = 16'h0040;
      stepCycles(3);
      readCount(first, t0);
      stepCycles(300);
      readCount(got, t1);
      checkRange("count growth 1 Hz", got - first, (t1 - t0) / 100 - 1, (t1 - t0) / 100 + 1);
      finishTest("tick rates", fails);

      fails = failCnt;
      for (n = 0; n < 3; n++)
      begin
         btns = 5'($urandom());
         swRand = $urandom();
         sw = {swRand[15:8], 4'hA, swRand[3:0]};
         stepCycles(3);
         collectScan(got, t0);
         checkValue("port I", got, {27'd0, btns});
         sw[7:4] = 4'hB;
         stepCycles(3);
         collectScan(got, t0);
         checkValue("port J", got, {16'd0, sw});
      end
      finishTest("ports I and J", fails);

      $display("%0d tests run, %0d failed checks", testCnt, failCnt);
      if (failCnt == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* all.f */
src/boardTestPkg.sv
src/tickGen.sv
src/inputSampler.sv
src/eventCounter.sv
src/displayMux.sv
src/segScan.sv
src/boardTest.sv
tests/boardTest_checker.sv
tests/boardTestTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module boardTestTb \
   -f all.f -o boardTestSim &&
./obj_dir/boardTestSim | tee /dev/stderr | grep -q 'All tests passed!' &&
echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }
